/* pad_pkg.sv */
/*
 * chip pad shell package
 * pad counts, pinout table, power-on timing and the shared pad structs
 */
package pad_pkg;

  //////////////////////
  // pad counts
  //////////////////////

  // 0-13 gpio, 14-16 sw straps, 17-18 tap straps, 19 uart
  localparam int unsigned NMioPads = 20;
  localparam int unsigned PadIdxW  = 5;
  localparam int unsigned NGpio    = 32;
  localparam int unsigned UartPad  = 19;

  // gpio bit for each non-uart pad, everything else on the bus is a hole
  localparam int unsigned GpioPos [UartPad] = '{
    0, 1, 2, 3, 4, 5, 6,
    7, 8, 9, 10, 11, 12, 13,
    // sw straps
    22, 23, 24,
    // tap straps
    27, 30
  };

  //////////////////////
  // supply and por
  //////////////////////

  localparam int unsigned SupplyCntW = 4;

  // low, high, low, then high for good
  localparam logic [SupplyCntW-1:0] SupplyOnA  = 4'd4;
  localparam logic [SupplyCntW-1:0] SupplyOffB = 4'd8;
  localparam logic [SupplyCntW-1:0] SupplyOnC  = 4'd12;

  // consecutive high samples before the chip is let out of reset
  localparam int unsigned PorStable = 6;
  localparam int unsigned PorCntW   = $clog2(PorStable + 1);

  //////////////////////
  // structs
  //////////////////////

  typedef struct packed {
    logic pull_en;
    logic pull_select;
  } pad_attr_t;

  typedef struct packed {
    logic      out;
    logic      oe;
    pad_attr_t attr;
  } pad_ctrl_t;

  // host write to one pad control entry
  typedef struct packed {
    logic [PadIdxW-1:0] idx;
    pad_ctrl_t          ctrl;
  } pad_wr_t;

  // same bit order on all four vectors
  typedef struct packed {
    logic [NGpio-1:0] d2p;
    logic [NGpio-1:0] en;
    logic [NGpio-1:0] pull_en;
    logic [NGpio-1:0] pull_select;
  } gpio_out_t;

  typedef struct packed {
    logic tx;
    logic tx_en;
  } uart_out_t;

  typedef struct packed {
    logic [NMioPads-1:0] mio;
  } pad_in_t;

endpackage : pad_pkg

/* supply_seq.sv */
/*
 * fake supply sequencer
 * saturating counter on the always-on clock shaping a power-on supply
 */
`timescale 1ns/1ps

module supply_seq (
  input  logic clk_aon,
  input  logic rst_n_i,
  output logic vcc_supp_o
);

  import pad_pkg::*;

  logic [SupplyCntW-1:0] cnt_q;

  // count up once per cycle and park at all ones
  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (cnt_q != '1) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // one glitch before the supply settles high
  always_comb begin
    if (cnt_q < SupplyOnA) begin
      vcc_supp_o = 1'b0;
    end else if (cnt_q < SupplyOffB) begin
      vcc_supp_o = 1'b1;
    end else if (cnt_q < SupplyOnC) begin
      vcc_supp_o = 1'b0;
    end else begin
      vcc_supp_o = 1'b1;
    end
  end

endmodule : supply_seq

/* por_ctrl.sv */
/*
 * power-ok control
 * filters the supply and releases chip ready once it has been stable
 */
`timescale 1ns/1ps

module por_ctrl (
  input  logic clk_aon,
  input  logic rst_n_i,
  input  logic vcc_supp_i,
  output logic chip_rdy_o
);

  import pad_pkg::*;

  //////////////////////
  // stability counter
  //////////////////////

  logic [PorCntW-1:0] stable_cnt_q;
  logic               stable_hit;
  logic               chip_rdy_q;

  assign stable_hit = (stable_cnt_q == PorCntW'(PorStable));

  // consecutive high samples, any low sample starts over
  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stable_cnt_q <= '0;
    end else if (!vcc_supp_i) begin
      stable_cnt_q <= '0;
    end else if (!stable_hit) begin
      stable_cnt_q <= stable_cnt_q + 1'b1;
    end
  end

  //////////////////////
  // chip ready
  //////////////////////

  // one cycle behind the counter hitting the threshold,
  // short pulses never get there
  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      chip_rdy_q <= 1'b0;
    end else if (!vcc_supp_i) begin
      chip_rdy_q <= 1'b0;
    end else begin
      chip_rdy_q <= stable_hit;
    end
  end

  // also used as pad enable at the top
  assign chip_rdy_o = chip_rdy_q;

endmodule : por_ctrl

/* pad_reg_bank.sv */
/*
 * pad control register bank
 * one control entry per muxed pad, written over a valid/ready port
 */
`timescale 1ns/1ps

module pad_reg_bank (
  input  logic                                       clk_aon,
  input  logic                                       rst_n_i,
  input  logic                                       chip_rdy_i,
  input  logic                                       wr_valid_i,
  output logic                                       wr_ready_o,
  input  pad_pkg::pad_wr_t                           wr_i,
  output pad_pkg::pad_ctrl_t [pad_pkg::NMioPads-1:0] pad_ctrl_o
);

  import pad_pkg::*;

  pad_ctrl_t [NMioPads-1:0] pad_q;
  logic                     wr_fire;
  logic                     wr_in_range;

  //////////////////////
  // handshake
  //////////////////////

  // host is held off until power-ok
  assign wr_ready_o = chip_rdy_i;
  assign wr_fire    = wr_valid_i && wr_ready_o;

  // out of range writes complete but land nowhere
  assign wr_in_range = (wr_i.idx < PadIdxW'(NMioPads));

  //////////////////////
  // control registers
  //////////////////////

  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pad_q <= '0;
    end else if (!chip_rdy_i) begin
      // pads fall back to idle whenever power-ok drops
      pad_q <= '0;
    end else if (wr_fire && wr_in_range) begin
      pad_q[wr_i.idx] <= wr_i.ctrl;
    end
  end

  assign pad_ctrl_o = pad_q;

endmodule : pad_reg_bank

/* in_sync.sv */
/*
 * two-flop synchronizer for any packed payload
 */
`timescale 1ns/1ps

module in_sync #(
  parameter type T = logic
) (
  input  logic clk_aon,
  input  logic rst_n_i,
  input  T     d_i,
  output T     q_o
);

  T meta_q;
  T sync_q;

  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= d_i;
      sync_q <= meta_q;
    end
  end

  assign q_o = sync_q;

endmodule : in_sync

/* gpio_pinout.sv */
/*
 * fixed pinout
 * places pad controls on the gpio bus and uart pad, gathers pad inputs
 */
`timescale 1ns/1ps

module gpio_pinout (
  input  logic                                       pad_en_i,
  input  pad_pkg::pad_ctrl_t [pad_pkg::NMioPads-1:0] pad_ctrl_i,
  input  logic [pad_pkg::NGpio-1:0]                  gpio_p2d_i,
  input  logic                                       uart_rx_i,
  output pad_pkg::gpio_out_t                         gpio_o,
  output pad_pkg::uart_out_t                         uart_o,
  output pad_pkg::pad_in_t                           pad_in_o
);

  import pad_pkg::*;

  //////////////////////
  // outputs to pads
  //////////////////////

  // holes stay at the default zero, only mapped bits get written
  always_comb begin : scatter_gpio
    gpio_o = '0;
    if (pad_en_i) begin
      for (int unsigned p = 0; p < UartPad; p++) begin
        gpio_o.d2p[GpioPos[p]]         = pad_ctrl_i[p].out;
        gpio_o.en[GpioPos[p]]          = pad_ctrl_i[p].oe;
        gpio_o.pull_en[GpioPos[p]]     = pad_ctrl_i[p].attr.pull_en;
        gpio_o.pull_select[GpioPos[p]] = pad_ctrl_i[p].attr.pull_select;
      end
    end
  end

  // uart tx sits on its own pad, pull is not brought out
  always_comb begin : drive_uart
    uart_o = '0;
    if (pad_en_i) begin
      uart_o.tx    = pad_ctrl_i[UartPad].out;
      uart_o.tx_en = pad_ctrl_i[UartPad].oe;
    end
  end

  //////////////////////
  // inputs from pads
  //////////////////////

  // same table in reverse, rx lands on the uart pad
  always_comb begin : gather_inputs
    pad_in_o = '0;
    for (int unsigned p = 0; p < UartPad; p++) begin
      pad_in_o.mio[p] = gpio_p2d_i[GpioPos[p]];
    end
    pad_in_o.mio[UartPad] = uart_rx_i;
  end

endmodule : gpio_pinout

/* chip_pad_shell.sv */
/*
 * chip pad shell top
 * power-on sequencing, pad control bank and gpio/uart pinout
 */
`timescale 1ns/1ps

module chip_pad_shell (
  input  logic                      clk_aon,
  input  logic                      rst_n_i,

  // host pad write port
  input  logic                      pad_wr_valid_i,
  output logic                      pad_wr_ready_o,
  input  pad_pkg::pad_wr_t          pad_wr_i,

  // pads
  input  logic [pad_pkg::NGpio-1:0] gpio_p2d_i,
  input  logic                      uart_rx_i,
  output pad_pkg::gpio_out_t        gpio_o,
  output pad_pkg::uart_out_t        uart_o,
  output pad_pkg::pad_in_t          pad_in_o,

  output logic                      chip_rdy_o
);

  import pad_pkg::*;

  logic                     vcc_supp;
  logic                     vcc_supp_sync;
  logic                     chip_rdy;
  pad_ctrl_t [NMioPads-1:0] pad_ctrl;
  pad_in_t                  pad_in_raw;

  //////////////////////
  // power-on
  //////////////////////

  supply_seq u_supply_seq (
    .clk_aon    (clk_aon),
    .rst_n_i    (rst_n_i),
    .vcc_supp_o (vcc_supp)
  );

  // supply would be asynchronous on silicon
  in_sync #(
    .T (logic)
  ) u_supply_sync (
    .clk_aon (clk_aon),
    .rst_n_i (rst_n_i),
    .d_i     (vcc_supp),
    .q_o     (vcc_supp_sync)
  );

  por_ctrl u_por_ctrl (
    .clk_aon    (clk_aon),
    .rst_n_i    (rst_n_i),
    .vcc_supp_i (vcc_supp_sync),
    .chip_rdy_o (chip_rdy)
  );

  assign chip_rdy_o = chip_rdy;

  //////////////////////
  // pad datapath
  //////////////////////

  pad_reg_bank u_pad_reg_bank (
    .clk_aon    (clk_aon),
    .rst_n_i    (rst_n_i),
    .chip_rdy_i (chip_rdy),
    .wr_valid_i (pad_wr_valid_i),
    .wr_ready_o (pad_wr_ready_o),
    .wr_i       (pad_wr_i),
    .pad_ctrl_o (pad_ctrl)
  );

  // chip ready doubles as the pad enable
  gpio_pinout u_gpio_pinout (
    .pad_en_i   (chip_rdy),
    .pad_ctrl_i (pad_ctrl),
    .gpio_p2d_i (gpio_p2d_i),
    .uart_rx_i  (uart_rx_i),
    .gpio_o     (gpio_o),
    .uart_o     (uart_o),
    .pad_in_o   (pad_in_raw)
  );

  in_sync #(
    .T (pad_in_t)
  ) u_pad_in_sync (
    .clk_aon (clk_aon),
    .rst_n_i (rst_n_i),
    .d_i     (pad_in_raw),
    .q_o     (pad_in_o)
  );

endmodule : chip_pad_shell

/* chip_pad_shell_asserts.sv */
/*
 * chip pad shell assertions
 * pinout holes, output enables before power-ok, write ready
 */
`timescale 1ns/1ps

module chip_pad_shell_asserts (
  input logic               clk_aon,
  input logic               rst_n_i,
  input pad_pkg::gpio_out_t gpio_i,
  input pad_pkg::uart_out_t uart_i,
  input logic               chip_rdy_i,
  input logic               pad_wr_ready_i
);

  import pad_pkg::*;

  // every bus bit except 0-13, 22-24, 27 and 30
  localparam logic [NGpio-1:0] HoleMask = 32'hB63F_C000;

  logic [NGpio-1:0] any_drive;

  assign any_drive = gpio_i.d2p | gpio_i.en | gpio_i.pull_en | gpio_i.pull_select;

  a_holes_zero: assert property (@(posedge clk_aon) disable iff (!rst_n_i)
    (any_drive & HoleMask) == '0)
    else $error("gpio hole bit driven, bus 0x%0h", any_drive);

  // pads stay quiet until power-ok
  a_no_oe_before_rdy: assert property (@(posedge clk_aon) disable iff (!rst_n_i)
    !chip_rdy_i |-> (gpio_i.en == '0 && !uart_i.tx_en))
    else $error("output enable set while chip not ready");

  a_ready_is_rdy: assert property (@(posedge clk_aon) disable iff (!rst_n_i)
    pad_wr_ready_i == chip_rdy_i)
    else $error("pad write ready differs from chip ready");

endmodule : chip_pad_shell_asserts

bind chip_pad_shell chip_pad_shell_asserts chip_pad_shell_asserts_inst (
  .clk_aon        (clk_aon),
  .rst_n_i        (rst_n_i),
  .gpio_i         (gpio_o),
  .uart_i         (uart_o),
  .chip_rdy_i     (chip_rdy_o),
  .pad_wr_ready_i (pad_wr_ready_o)
);

/* chip_pad_shell_tb.sv */
/*
 * chip pad shell testbench
 * power-on, table driven pad writes, ignored writes and pad input capture
 */
`timescale 1ns/1ps

module chip_pad_shell_tb;

  import pad_pkg::*;

  localparam int RstCycles  = 2;
  localparam int PorCycles  = 62;
  localparam int NRows      = 12;
  localparam int WrCycles   = 8;
  localparam int NRand      = 8;
  localparam int RandCycles = 3;
  // twice the budget for reset, power-on, every write and the input samples
  localparam int TimeoutCycles =
    2 * (RstCycles + PorCycles + (NRows + 2) * WrCycles + NRand * RandCycles);

  typedef struct {
    logic [PadIdxW-1:0] idx;
    pad_ctrl_t          ctrl;
    int                 exp_bit;  // -1 marks the uart pad
  } row_t;

  logic             clk_aon;
  logic             rst_n_i;
  logic             pad_wr_valid_i;
  logic             pad_wr_ready_o;
  pad_wr_t          pad_wr_i;
  logic [NGpio-1:0] gpio_p2d_i;
  logic             uart_rx_i;
  gpio_out_t        gpio_o;
  uart_out_t        uart_o;
  pad_in_t          pad_in_o;
  logic             chip_rdy_o;

  row_t        rows [NRows];
  gpio_out_t   exp_gpio;
  uart_out_t   exp_uart;
  pad_in_t     exp_in;
  logic [31:0] rnd_state;
  int          n_checks;
  int          n_errors;
  int          cycle_cnt = 0;

  chip_pad_shell chip_pad_shell_inst (
    .clk_aon        (clk_aon),
    .rst_n_i        (rst_n_i),
    .pad_wr_valid_i (pad_wr_valid_i),
    .pad_wr_ready_o (pad_wr_ready_o),
    .pad_wr_i       (pad_wr_i),
    .gpio_p2d_i     (gpio_p2d_i),
    .uart_rx_i      (uart_rx_i),
    .gpio_o         (gpio_o),
    .uart_o         (uart_o),
    .pad_in_o       (pad_in_o),
    .chip_rdy_o     (chip_rdy_o)
  );

  initial begin
    clk_aon = 1'b0;
    forever #2 clk_aon = ~clk_aon;
  end

  always @(posedge clk_aon) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("ERROR: run stopped after %0d cycles, chip ready or a write never came",
               cycle_cnt);
      $display("checks: %0d, errors: %0d", n_checks, n_errors + 1);
      $display("** FAIL **");
      $finish;
    end
  end

  //////////////////////
  // reference model
  //////////////////////

  // gpio 0-13 straight through, sw straps at 22-24, tap straps at 27 and 30
  function automatic int gpio_bit_of(input int pad);
    if (pad <= 13) return pad;
    if (pad <= 16) return pad + 8;
    if (pad == 17) return 27;
    if (pad == 18) return 30;
    return -1;
  endfunction

  function automatic logic [NGpio-1:0] mapped_bits();
    logic [NGpio-1:0] m;
    m = '0;
    for (int p = 0; p < int'(UartPad); p++) begin
      m[gpio_bit_of(p)] = 1'b1;
    end
    return m;
  endfunction

  function automatic pad_in_t gather_inputs(input logic [NGpio-1:0] p2d, input logic rx);
    pad_in_t v;
    for (int p = 0; p < int'(UartPad); p++) begin
      v.mio[p] = p2d[gpio_bit_of(p)];
    end
    v.mio[UartPad] = rx;
    return v;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  //////////////////////
  // tasks
  //////////////////////

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic set_row(input int i, input int idx, input pad_ctrl_t ctrl);
    rows[i].idx     = PadIdxW'(idx);
    rows[i].ctrl    = ctrl;
    rows[i].exp_bit = gpio_bit_of(idx);
  endtask

  // returns on the negedge after the accepting edge
  task automatic write_pad(input pad_wr_t wr);
    @(posedge clk_aon);
    pad_wr_valid_i <= 1'b1;
    pad_wr_i       <= wr;
    @(negedge clk_aon);
    while (!pad_wr_ready_o) begin
      // nothing may reach the pads before power-ok
      check_value("gpio_o", gpio_o, exp_gpio);
      check_value("uart_o", 128'(uart_o), 128'(exp_uart));
      @(negedge clk_aon);
    end
    @(posedge clk_aon);
    pad_wr_valid_i <= 1'b0;
    @(negedge clk_aon);
  endtask

  task automatic apply_row(input row_t r);
    pad_wr_t wr;
    int      b;
    wr.idx  = r.idx;
    wr.ctrl = r.ctrl;
    b       = r.exp_bit;
    write_pad(wr);
    if (b < 0) begin
      exp_uart.tx    = r.ctrl.out;
      exp_uart.tx_en = r.ctrl.oe;
      check_value("uart_o", 128'(uart_o), 128'(exp_uart));
    end else begin
      exp_gpio.d2p[b]         = r.ctrl.out;
      exp_gpio.en[b]          = r.ctrl.oe;
      exp_gpio.pull_en[b]     = r.ctrl.attr.pull_en;
      exp_gpio.pull_select[b] = r.ctrl.attr.pull_select;
      check_value($sformatf("gpio_o.d2p[%0d]", b), 128'(gpio_o.d2p[b]), 128'(r.ctrl.out));
      check_value($sformatf("gpio_o.en[%0d]", b), 128'(gpio_o.en[b]), 128'(r.ctrl.oe));
      check_value($sformatf("gpio_o.pull_en[%0d]", b), 128'(gpio_o.pull_en[b]),
                  128'(r.ctrl.attr.pull_en));
      check_value($sformatf("gpio_o.pull_select[%0d]", b), 128'(gpio_o.pull_select[b]),
                  128'(r.ctrl.attr.pull_select));
    end
    check_value("gpio_o", gpio_o, exp_gpio);
    check_value("gpio_o holes", 128'((gpio_o.d2p | gpio_o.en | gpio_o.pull_en |
                gpio_o.pull_select) & ~mapped_bits()), 128'(0));
  endtask

  // index past the last pad, handshake completes and nothing moves
  task automatic check_ignored(input logic [PadIdxW-1:0] idx);
    pad_wr_t wr;
    wr.idx  = idx;
    wr.ctrl = 4'b1111;
    write_pad(wr);
    check_value("gpio_o", gpio_o, exp_gpio);
    check_value("uart_o", 128'(uart_o), 128'(exp_uart));
  endtask

  //////////////////////
  // main sequence
  //////////////////////

  initial begin
    // pad index, {out, oe, pull_en, pull_select}
    set_row(0, 0, 4'b1100);
    set_row(1, 5, 4'b0111);
    set_row(2, 13, 4'b1010);
    set_row(3, 14, 4'b1111);
    set_row(4, 15, 4'b0011);
    set_row(5, 16, 4'b1101);
    set_row(6, 17, 4'b1110);
    set_row(7, 18, 4'b0101);
    set_row(8, 19, 4'b1100);
    set_row(9, 0, 4'b0011);
    set_row(10, 19, 4'b0111);
    set_row(11, 7, 4'b1111);

    // valid is up from reset on, carrying the first row
    rst_n_i        = 1'b0;
    pad_wr_valid_i = 1'b1;
    pad_wr_i.idx   = rows[0].idx;
    pad_wr_i.ctrl  = rows[0].ctrl;
    gpio_p2d_i     = '0;
    uart_rx_i      = 1'b0;
    exp_gpio       = '0;
    exp_uart       = '0;
    rnd_state      = 32'd79503;
    n_checks       = 0;
    n_errors       = 0;

    repeat (RstCycles) @(posedge clk_aon);
    rst_n_i <= 1'b1;
    @(negedge clk_aon);
    check_value("chip_rdy_o", 128'(chip_rdy_o), 128'(0));
    check_value("pad_wr_ready_o", 128'(pad_wr_ready_o), 128'(0));
    check_value("gpio_o", gpio_o, 128'(0));
    check_value("uart_o", 128'(uart_o), 128'(0));

    for (int i = 0; i < NRows; i++) begin
      apply_row(rows[i]);
    end
    check_value("chip_rdy_o", 128'(chip_rdy_o), 128'(1));

    check_ignored(5'd20);
    check_ignored(5'd31);

    // pad inputs, two flops of latency
    for (int i = 0; i < NRand; i++) begin
      rnd_state = xorshift32(rnd_state);
      exp_in    = gather_inputs(rnd_state, rnd_state[31]);
      @(posedge clk_aon);
      gpio_p2d_i <= rnd_state;
      uart_rx_i  <= rnd_state[31];
      repeat (2) @(posedge clk_aon);
      @(negedge clk_aon);
      check_value("pad_in_o", 128'(pad_in_o), 128'(exp_in));
    end

    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule : chip_pad_shell_tb

/* flist.f */
pad_pkg.sv
supply_seq.sv
por_ctrl.sv
pad_reg_bank.sv
in_sync.sv
gpio_pinout.sv
chip_pad_shell.sv
chip_pad_shell_asserts.sv
chip_pad_shell_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = chip_pad_shell_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SRCS      = $(filter %.sv,$(shell cat $(FLIST)))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the log decides pass or fail
run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
